/* hw/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath widths
`define WORD_WIDTH     32
`define REG_ADDR_WIDTH 5
`define REG_COUNT      32
`define ZERO_WORD      32'h0000_0000
// first fetch address after reset
`define RESET_PC       32'h0000_0000
// link register written by jal
`define RA_REG         5'd31

// primary opcodes
`define OPCODE_SPECIAL 6'b000000
`define OPCODE_J       6'b000010
`define OPCODE_JAL     6'b000011
`define OPCODE_ADDIU   6'b001001
`define OPCODE_ANDI    6'b001100
`define OPCODE_ORI     6'b001101
`define OPCODE_XORI    6'b001110
`define OPCODE_LUI     6'b001111

// funct codes under SPECIAL
`define FUNCT_SLL  6'b000000
`define FUNCT_ADDU 6'b100001
`define FUNCT_SUBU 6'b100011
`define FUNCT_AND  6'b100100
`define FUNCT_OR   6'b100101
`define FUNCT_XOR  6'b100110
`define FUNCT_SLT  6'b101010

`endif

/* hw/cpu_pkg.sv */
`include "cpu_defs.svh"

package cpu_pkg;

	// one data word
	typedef logic [`WORD_WIDTH-1:0] Word_t;
	// byte address of an instruction
	typedef logic [`WORD_WIDTH-1:0] InstAddr_t;
	// raw instruction word
	typedef logic [`WORD_WIDTH-1:0] Inst_t;
	// register number
	typedef logic [`REG_ADDR_WIDTH-1:0] RegAddr_t;

	// operations the alu understands
	// immediate forms reuse the register forms
	typedef enum logic [3:0] {
		OP_ADDU,
		OP_SUBU,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_SLL,
		OP_LUI,
		OP_J,
		OP_JAL,
		OP_INVALID
	} Oper_t;

	// one pending register write
	typedef struct packed {
		logic     we;
		RegAddr_t waddr;
		Word_t    wdata;
	} RegWriteReq_t;

	// decoded instruction handed from decode to execute
	typedef struct packed {
		Oper_t    op;
		Word_t    reg1;
		Word_t    reg2;
		logic     reg_we;
		RegAddr_t reg_waddr;
		logic     valid;
	} DecOut_t;

endpackage

/* hw/rf_read_if.sv */
`timescale 1ns/1ns

// two combinational register read ports
interface rf_read_if;

	// addresses from decode
	cpu_pkg::RegAddr_t raddr1;
	cpu_pkg::RegAddr_t raddr2;
	// data back from the register file
	cpu_pkg::Word_t    rdata1;
	cpu_pkg::Word_t    rdata2;

	modport decoder (
		output raddr1,
		output raddr2,
		input  rdata1,
		input  rdata2
	);

	modport regfile (
		input  raddr1,
		input  raddr2,
		output rdata1,
		output rdata2
	);

endinterface

/* hw/cpu_if_fetch.sv */
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_if_fetch (
	input  logic               clk,
	input  logic               rst_n_i,
	// wishbone classic read master
	output logic               wb_cyc_o,
	output logic               wb_stb_o,
	output cpu_pkg::InstAddr_t wb_adr_o,
	input  cpu_pkg::Inst_t     wb_dat_i,
	input  logic               wb_ack_i,
	// redirect from decode
	input  logic               jump_i,
	input  cpu_pkg::InstAddr_t jump_target_i,
	// if/id register
	output cpu_pkg::Inst_t     inst_o,
	output cpu_pkg::InstAddr_t pc_o,
	output logic               inst_valid_o
);

	// request active, cyc and stb share it
	logic               req_q;
	// address of the fetch on the bus
	cpu_pkg::InstAddr_t pc_q;
	// jump seen before the delay slot was acked
	logic               redirect_q;
	cpu_pkg::InstAddr_t redirect_target_q;
	logic               fetch_done;
	cpu_pkg::InstAddr_t next_pc;

	assign wb_cyc_o   = req_q;
	assign wb_stb_o   = req_q;
	assign wb_adr_o   = pc_q;
	assign fetch_done = req_q & wb_ack_i;

	// a jump in id always belongs to the fetch now in flight, the delay slot
	always_comb begin
		if (jump_i) begin
			next_pc = jump_target_i;
		end else if (redirect_q) begin
			next_pc = redirect_target_q;
		end else begin
			next_pc = pc_q + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			req_q        <= 1'b0;
			pc_q         <= `RESET_PC;
			redirect_q   <= 1'b0;
			inst_valid_o <= 1'b0;
		end else begin
			// back to back requests once out of reset
			req_q        <= 1'b1;
			// no ack means a bubble into id
			inst_valid_o <= fetch_done;
			if (fetch_done) begin
				pc_q       <= next_pc;
				redirect_q <= 1'b0;
			end else if (jump_i) begin
				// slot still pending, hold the target until its ack
				redirect_q <= 1'b1;
			end
		end
	end

	// payload side
	always_ff @(posedge clk) begin
		if (jump_i) begin
			redirect_target_q <= jump_target_i;
		end
		if (fetch_done) begin
			inst_o <= wb_dat_i;
			pc_o   <= pc_q;
		end
	end

endmodule

/* hw/cpu_id.sv */
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_id (
	input  logic                  rst_n_i,
	input  cpu_pkg::InstAddr_t    pc_i,
	input  cpu_pkg::Inst_t        inst_i,
	input  logic                  inst_valid_i,
	rf_read_if.decoder            rf,
	// results not yet in the register file
	input  cpu_pkg::RegWriteReq_t ex_wr_i,
	input  cpu_pkg::RegWriteReq_t wb_wr_i,
	output cpu_pkg::DecOut_t      dec_o,
	// redirect to fetch
	output logic                  jump_o,
	output cpu_pkg::InstAddr_t    jump_target_o
);

	// instruction fields
	logic [5:0]         opcode;
	cpu_pkg::RegAddr_t  rs;
	cpu_pkg::RegAddr_t  rt;
	cpu_pkg::RegAddr_t  rd;
	logic [4:0]         sa;
	logic [5:0]         funct;
	logic [15:0]        immediate;
	logic [25:0]        instr_index;

	logic               inst_ok;
	// operands after forwarding
	cpu_pkg::Word_t     safe_rs;
	cpu_pkg::Word_t     safe_rt;
	cpu_pkg::Word_t     imm_zero_ext;
	cpu_pkg::Word_t     imm_sign_ext;
	// address of the delay slot
	cpu_pkg::InstAddr_t slot_pc;
	logic               writes;
	cpu_pkg::RegAddr_t  waddr;

	// newest pending write wins, then older, then the file
	function automatic cpu_pkg::Word_t forward(
		input cpu_pkg::RegAddr_t     addr,
		input cpu_pkg::Word_t        rf_val,
		input cpu_pkg::RegWriteReq_t ex_wr,
		input cpu_pkg::RegWriteReq_t wb_wr
	);
		cpu_pkg::Word_t val;
		if (addr == '0) begin
			val = `ZERO_WORD;
		end else if (ex_wr.we && ex_wr.waddr == addr) begin
			val = ex_wr.wdata;
		end else if (wb_wr.we && wb_wr.waddr == addr) begin
			val = wb_wr.wdata;
		end else begin
			val = rf_val;
		end
		return val;
	endfunction

	assign opcode      = inst_i[31:26];
	assign rs          = inst_i[25:21];
	assign rt          = inst_i[20:16];
	assign rd          = inst_i[15:11];
	assign sa          = inst_i[10:6];
	assign funct       = inst_i[5:0];
	assign immediate   = inst_i[15:0];
	assign instr_index = inst_i[25:0];

	// no decode while in reset
	assign inst_ok = inst_valid_i & rst_n_i;

	assign rf.raddr1 = rs;
	assign rf.raddr2 = rt;
	assign safe_rs   = forward(rs, rf.rdata1, ex_wr_i, wb_wr_i);
	assign safe_rt   = forward(rt, rf.rdata2, ex_wr_i, wb_wr_i);

	assign imm_zero_ext = {16'h0, immediate};
	assign imm_sign_ext = {{16{immediate[15]}}, immediate};

	// region of the delay slot plus the word index
	assign slot_pc       = pc_i + 32'd4;
	assign jump_target_o = {slot_pc[31:28], instr_index, 2'b00};
	assign jump_o = inst_ok & (opcode == `OPCODE_J || opcode == `OPCODE_JAL);

	always_comb begin
		dec_o.op   = cpu_pkg::OP_INVALID;
		dec_o.reg1 = safe_rs;
		dec_o.reg2 = safe_rt;
		writes     = 1'b0;
		// r-type target by default
		waddr      = rd;
		case (opcode)
			`OPCODE_SPECIAL: begin
				writes = 1'b1;
				case (funct)
					`FUNCT_ADDU: dec_o.op = cpu_pkg::OP_ADDU;
					`FUNCT_SUBU: dec_o.op = cpu_pkg::OP_SUBU;
					`FUNCT_AND:  dec_o.op = cpu_pkg::OP_AND;
					`FUNCT_OR:   dec_o.op = cpu_pkg::OP_OR;
					`FUNCT_XOR:  dec_o.op = cpu_pkg::OP_XOR;
					`FUNCT_SLT:  dec_o.op = cpu_pkg::OP_SLT;
					`FUNCT_SLL: begin
						// shift amount rides in operand 1
						dec_o.op   = cpu_pkg::OP_SLL;
						dec_o.reg1 = {27'b0, sa};
					end
					default: writes = 1'b0;
				endcase
			end
			`OPCODE_ADDIU: begin
				dec_o.op   = cpu_pkg::OP_ADDU;
				dec_o.reg2 = imm_sign_ext;
				writes     = 1'b1;
				waddr      = rt;
			end
			`OPCODE_ANDI: begin
				dec_o.op   = cpu_pkg::OP_AND;
				dec_o.reg2 = imm_zero_ext;
				writes     = 1'b1;
				waddr      = rt;
			end
			`OPCODE_ORI: begin
				dec_o.op   = cpu_pkg::OP_OR;
				dec_o.reg2 = imm_zero_ext;
				writes     = 1'b1;
				waddr      = rt;
			end
			`OPCODE_XORI: begin
				dec_o.op   = cpu_pkg::OP_XOR;
				dec_o.reg2 = imm_zero_ext;
				writes     = 1'b1;
				waddr      = rt;
			end
			`OPCODE_LUI: begin
				// alu moves the low half up
				dec_o.op   = cpu_pkg::OP_LUI;
				dec_o.reg2 = imm_zero_ext;
				writes     = 1'b1;
				waddr      = rt;
			end
			`OPCODE_J: begin
				dec_o.op   = cpu_pkg::OP_J;
				dec_o.reg1 = `ZERO_WORD;
				dec_o.reg2 = `ZERO_WORD;
			end
			`OPCODE_JAL: begin
				// link past the delay slot
				dec_o.op   = cpu_pkg::OP_JAL;
				dec_o.reg1 = pc_i + 32'd8;
				dec_o.reg2 = `ZERO_WORD;
				writes     = 1'b1;
				waddr      = `RA_REG;
			end
			default: begin
				writes = 1'b0;
			end
		endcase
		dec_o.valid     = inst_ok;
		// writes to $0 are dropped here
		dec_o.reg_we    = inst_ok & writes & (waddr != '0);
		dec_o.reg_waddr = waddr;
	end

endmodule

/* hw/cpu_ex.sv */
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_ex (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  cpu_pkg::DecOut_t      dec_i,
	// result of the instruction in id/ex
	output cpu_pkg::RegWriteReq_t ex_wr_o,
	// ex/wb register, the committing instruction
	output cpu_pkg::RegWriteReq_t wb_wr_o
);

	// id/ex register
	cpu_pkg::DecOut_t      dec_q;
	cpu_pkg::Word_t        alu_result;
	cpu_pkg::RegWriteReq_t ex_wr;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			// only the control bits need clearing
			dec_q.valid  <= 1'b0;
			dec_q.reg_we <= 1'b0;
		end else begin
			dec_q <= dec_i;
		end
	end

	// alu
	always_comb begin
		case (dec_q.op)
			cpu_pkg::OP_ADDU: alu_result = dec_q.reg1 + dec_q.reg2;
			cpu_pkg::OP_SUBU: alu_result = dec_q.reg1 - dec_q.reg2;
			cpu_pkg::OP_AND:  alu_result = dec_q.reg1 & dec_q.reg2;
			cpu_pkg::OP_OR:   alu_result = dec_q.reg1 | dec_q.reg2;
			cpu_pkg::OP_XOR:  alu_result = dec_q.reg1 ^ dec_q.reg2;
			cpu_pkg::OP_SLT: begin
				// signed compare
				if ($signed(dec_q.reg1) < $signed(dec_q.reg2)) begin
					alu_result = 32'd1;
				end else begin
					alu_result = `ZERO_WORD;
				end
			end
			// operand 2 shifted by sa in operand 1
			cpu_pkg::OP_SLL:  alu_result = dec_q.reg2 << dec_q.reg1[4:0];
			cpu_pkg::OP_LUI:  alu_result = {dec_q.reg2[15:0], 16'h0};
			// link address comes precomputed
			cpu_pkg::OP_JAL:  alu_result = dec_q.reg1;
			default:          alu_result = `ZERO_WORD;
		endcase
	end

	// bubbles never request a write
	assign ex_wr.we    = dec_q.valid & dec_q.reg_we;
	assign ex_wr.waddr = dec_q.reg_waddr;
	assign ex_wr.wdata = alu_result;
	assign ex_wr_o     = ex_wr;

	// ex/wb, also the commit trace so cleared fully
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wb_wr_o <= '0;
		end else begin
			wb_wr_o <= ex_wr;
		end
	end

endmodule

/* hw/cpu_regfile.sv */
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_regfile (
	input  logic                  clk,
	input  logic                  rst_n_i,
	rf_read_if.regfile            rf,
	input  cpu_pkg::RegWriteReq_t wr_i
);

	// $1..$31, $0 is not stored
	cpu_pkg::Word_t regs [1:`REG_COUNT-1];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 1; i < `REG_COUNT; i++) begin
				regs[i] <= `ZERO_WORD;
			end
		end else if (wr_i.we && wr_i.waddr != '0) begin
			regs[wr_i.waddr] <= wr_i.wdata;
		end
	end

	// read port 1
	always_comb begin
		if (rf.raddr1 == '0) begin
			rf.rdata1 = `ZERO_WORD;
		end else begin
			rf.rdata1 = regs[rf.raddr1];
		end
	end

	// read port 2
	always_comb begin
		if (rf.raddr2 == '0) begin
			rf.rdata2 = `ZERO_WORD;
		end else begin
			rf.rdata2 = regs[rf.raddr2];
		end
	end

endmodule

/* hw/cpu_core.sv */
`timescale 1ns/1ns

module cpu_core (
	input  logic               clk,
	input  logic               rst_n_i,
	// instruction fetch, wishbone classic
	output logic               wb_cyc_o,
	output logic               wb_stb_o,
	output cpu_pkg::InstAddr_t wb_adr_o,
	input  cpu_pkg::Inst_t     wb_dat_i,
	input  logic               wb_ack_i,
	// commit trace, the register file write port
	output logic               rf_we_o,
	output cpu_pkg::RegAddr_t  rf_waddr_o,
	output cpu_pkg::Word_t     rf_wdata_o
);

	// if/id
	cpu_pkg::Inst_t        if_inst;
	cpu_pkg::InstAddr_t    if_pc;
	logic                  if_valid;
	// redirect from decode
	logic                  jump;
	cpu_pkg::InstAddr_t    jump_target;
	// decode to execute
	cpu_pkg::DecOut_t      dec;
	// pending writes for forwarding
	cpu_pkg::RegWriteReq_t ex_wr;
	cpu_pkg::RegWriteReq_t wb_wr;

	rf_read_if rf_read ();

	cpu_if_fetch fetch_inst (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.wb_cyc_o      (wb_cyc_o),
		.wb_stb_o      (wb_stb_o),
		.wb_adr_o      (wb_adr_o),
		.wb_dat_i      (wb_dat_i),
		.wb_ack_i      (wb_ack_i),
		.jump_i        (jump),
		.jump_target_i (jump_target),
		.inst_o        (if_inst),
		.pc_o          (if_pc),
		.inst_valid_o  (if_valid)
	);

	cpu_id id_inst (
		.rst_n_i       (rst_n_i),
		.pc_i          (if_pc),
		.inst_i        (if_inst),
		.inst_valid_i  (if_valid),
		.rf            (rf_read.decoder),
		.ex_wr_i       (ex_wr),
		.wb_wr_i       (wb_wr),
		.dec_o         (dec),
		.jump_o        (jump),
		.jump_target_o (jump_target)
	);

	cpu_ex ex_inst (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.dec_i   (dec),
		.ex_wr_o (ex_wr),
		.wb_wr_o (wb_wr)
	);

	cpu_regfile regfile_inst (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.rf      (rf_read.regfile),
		.wr_i    (wb_wr)
	);

	// commit is the ex/wb entry
	assign rf_we_o    = wb_wr.we;
	assign rf_waddr_o = wb_wr.waddr;
	assign rf_wdata_o = wb_wr.wdata;

endmodule

/* tests/cpu_core_assertions.sv */
`timescale 1ns/1ns

module cpu_core_assertions (
	input logic               clk,
	input logic               rst_n_i,
	input logic               wb_cyc_o,
	input logic               wb_stb_o,
	input cpu_pkg::InstAddr_t wb_adr_o,
	input logic               wb_ack_i,
	input logic               rf_we_o,
	input cpu_pkg::RegAddr_t  rf_waddr_o
);

	// failed assertions so far, watched from the testbench
	int fail_count = 0;

	// strobe only inside a cycle
	stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
		wb_stb_o |-> wb_cyc_o)
		else begin
			fail_count++;
			$error("wishbone stb high while cyc is low");
		end

	// address held until the slave acks
	adr_held: assert property (@(posedge clk) disable iff (!rst_n_i)
		(wb_stb_o && !wb_ack_i) |=> $stable(wb_adr_o))
		else begin
			fail_count++;
			$error("wishbone address changed before ack");
		end

	// $0 is never a commit target
	no_r0_commit: assert property (@(posedge clk) disable iff (!rst_n_i)
		rf_we_o |-> (rf_waddr_o != '0))
		else begin
			fail_count++;
			$error("commit to register 0");
		end

	// bus idle while reset is held
	cyc_low_in_reset: assert property (@(posedge clk)
		!rst_n_i |=> !wb_cyc_o)
		else begin
			fail_count++;
			$error("wishbone cyc high during reset");
		end

endmodule

bind cpu_core cpu_core_assertions assertions_inst (
	.clk        (clk),
	.rst_n_i    (rst_n_i),
	.wb_cyc_o   (wb_cyc_o),
	.wb_stb_o   (wb_stb_o),
	.wb_adr_o   (wb_adr_o),
	.wb_ack_i   (wb_ack_i),
	.rf_we_o    (rf_we_o),
	.rf_waddr_o (rf_waddr_o)
);

/* tests/cpu_core_tb.sv */
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_core_tb;

	logic                  clk;
	logic                  rst_n_i;
	logic                  wb_cyc_o;
	logic                  wb_stb_o;
	cpu_pkg::InstAddr_t    wb_adr_o;
	cpu_pkg::Inst_t        wb_dat_i;
	logic                  wb_ack_i;
	logic                  rf_we_o;
	cpu_pkg::RegAddr_t     rf_waddr_o;
	cpu_pkg::Word_t        rf_wdata_o;

	// program image, words past prog_len read as nop
	cpu_pkg::Inst_t        prog_mem [0:63];
	int                    prog_len = 0;
	// expected commit list in program order
	cpu_pkg::RegAddr_t     exp_reg [$];
	cpu_pkg::Word_t        exp_val [$];
	int                    exp_count = 0;
	int                    commit_idx = 0;
	int                    acks = 0;
	bit                    first_req_seen = 1'b0;
	bit                    loaded = 1'b0;
	// wait states on the bus, off for the back to back pass
	bit                    random_delay = 1'b0;

	cpu_core cpu_core_inst (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.wb_cyc_o   (wb_cyc_o),
		.wb_stb_o   (wb_stb_o),
		.wb_adr_o   (wb_adr_o),
		.wb_dat_i   (wb_dat_i),
		.wb_ack_i   (wb_ack_i),
		.rf_we_o    (rf_we_o),
		.rf_waddr_o (rf_waddr_o),
		.rf_wdata_o (rf_wdata_o)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_reg(input string name, input cpu_pkg::RegAddr_t got,
			input cpu_pkg::RegAddr_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_word(input string name, input cpu_pkg::Word_t got,
			input cpu_pkg::Word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input cpu_pkg::InstAddr_t got,
			input cpu_pkg::InstAddr_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// next value from the pattern file, '#' skips to end of line
	task automatic read_field(input int fd, input bit as_hex, output logic [31:0] val);
		string tok;
		string rest;
		int    n;
		bit    got;
		got = 1'b0;
		val = '0;
		while (!got) begin
			n = $fscanf(fd, "%s", tok);
			if (n != 1) begin
				abort_run("pattern file ended before all fields were read");
			end
			if (tok.getc(0) == "#") begin
				n = $fgets(rest, fd);
			end else begin
				if (as_hex) begin
					n = $sscanf(tok, "%h", val);
				end else begin
					n = $sscanf(tok, "%d", val);
				end
				got = 1'b1;
			end
		end
	endtask

	function automatic cpu_pkg::Inst_t fetch_word(input cpu_pkg::InstAddr_t adr);
		if (adr[31:2] < prog_len) begin
			return prog_mem[adr[7:2]];
		end else begin
			return `ZERO_WORD;
		end
	endfunction

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// wishbone slave, ack at once or after 0 to 3 idle cycles
	initial begin : memory_model
		integer seed;
		int     delay;
		seed     = 32'hc4119655;
		wb_ack_i = 1'b0;
		wb_dat_i = '0;
		forever begin
			@(negedge clk);
			// previous ack was taken on the rising edge
			wb_ack_i = 1'b0;
			if (rst_n_i && wb_cyc_o && wb_stb_o) begin
				if (random_delay) begin
					delay = {$random(seed)} % 4;
				end else begin
					delay = 0;
				end
				repeat (delay) @(negedge clk);
				wb_dat_i = fetch_word(wb_adr_o);
				wb_ack_i = 1'b1;
			end
		end
	end

	// count completed fetches as the dut sees them
	always @(posedge clk) begin
		if (!rst_n_i) begin
			acks = 0;
		end else if (wb_stb_o && wb_ack_i) begin
			acks++;
		end
	end

	// commit checker
	always @(negedge clk) begin
		if (cpu_core_inst.assertions_inst.fail_count != 0) begin
			abort_run("a bound protocol assertion failed");
		end
		if (rst_n_i && wb_stb_o && !first_req_seen) begin
			check_addr("wb_adr_o", wb_adr_o, `RESET_PC);
			first_req_seen = 1'b1;
		end
		if (rst_n_i && rf_we_o) begin
			if (acks == 0) begin
				abort_run("a commit appeared before any fetch was acknowledged");
			end
			if (commit_idx >= exp_count) begin
				abort_run("a commit appeared after the end of the program");
			end else begin
				check_reg("rf_waddr_o", rf_waddr_o, exp_reg[commit_idx]);
				check_word("rf_wdata_o", rf_wdata_o, exp_val[commit_idx]);
			end
			commit_idx++;
		end
	end

	// limit counts from each reset release
	initial begin : timeout_watch
		int cycles;
		int limit;
		cycles = 0;
		wait (loaded);
		limit = prog_len * 6 + 50;
		forever begin
			@(posedge clk);
			if (!rst_n_i) begin
				cycles = 0;
			end else begin
				cycles++;
			end
			if (cycles > limit) begin
				abort_run($sformatf("timeout after %0d cycles, commits still missing", limit));
			end
		end
	end

	initial begin : main_seq
		int          fd;
		logic [31:0] v;
		logic [31:0] r;
		rst_n_i = 1'b0;
		fd = $fopen("tests/cpu_core_patterns.txt", "r");
		if (fd == 0) begin
			abort_run("could not open tests/cpu_core_patterns.txt");
		end
		read_field(fd, 1'b0, v);
		prog_len = v;
		if (prog_len > 64) begin
			abort_run("program in the pattern file does not fit the memory model");
		end
		for (int i = 0; i < prog_len; i++) begin
			read_field(fd, 1'b1, v);
			prog_mem[i] = v;
		end
		read_field(fd, 1'b0, v);
		exp_count = v;
		for (int i = 0; i < exp_count; i++) begin
			read_field(fd, 1'b0, r);
			read_field(fd, 1'b1, v);
			exp_reg.push_back(r[4:0]);
			exp_val.push_back(v);
		end
		$fclose(fd);
		loaded = 1'b1;
		// pass 0 acks back to back so every forwarding path is hit
		// pass 1 adds random wait states
		for (int pass = 0; pass < 2; pass++) begin
			@(negedge clk);
			rst_n_i = 1'b0;
			repeat (10) @(posedge clk);
			commit_idx     = 0;
			first_req_seen = 1'b0;
			random_delay   = (pass == 1);
			@(negedge clk);
			rst_n_i = 1'b1;
			wait (commit_idx >= exp_count);
			// trailing nops must not commit
			repeat (8) @(negedge clk);
		end
		@(posedge clk);
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* sim.f */
+incdir+hw
hw/cpu_pkg.sv
hw/rf_read_if.sv
hw/cpu_if_fetch.sv
hw/cpu_id.sv
hw/cpu_ex.sv
hw/cpu_regfile.sv
hw/cpu_core.sv
tests/cpu_core_assertions.sv
tests/cpu_core_tb.sv

/* tests/cpu_core_patterns.txt */
# program: word count (decimal), then instruction words (hex) from address 0
# commits: commit count (decimal), then register (decimal) and value (hex) pairs in order
31
24010005 2402fffd  # addiu $1,$0,5 / addiu $2,$0,-3
00221821 00222023  # addu $3,$1,$2 / subu $4,$1,$2
0041282a 0022302a  # slt $5,$2,$1 / slt $6,$1,$2
3047f0f0 34288000  # andi $7,$2,0xf0f0 / ori $8,$1,0x8000
3849ffff 3c0a1234  # xori $9,$2,0xffff / lui $10,0x1234
00015900 01496024  # sll $11,$1,4 / and $12,$10,$9
01646825 240f0011  # or $13,$11,$4 / addiu $15,$0,0x11
25ef0100 01ed8026  # addiu $15,$15,0x100 / xor $16,$15,$13
24200007 00018821  # addiu $0,$1,7 / addu $17,$0,$1
0c000018 341200aa  # jal 0x60 / ori $18,$0,0xaa in the slot
24130bad 24140bad  # skipped by jal
24150bad 24160bad  # skipped by jal
0800001c 0001a823  # j 0x70 / subu $21,$0,$1 in the slot
24170bad 24180bad  # skipped by j
03f2b021 0016bf00  # addu $22,$31,$18 / sll $23,$22,28
02e0c02a           # slt $24,$23,$0
23
1 00000005   2 fffffffd   3 00000002
4 00000008   5 00000001   6 00000000
7 0000f0f0   8 00008005   9 ffff0002
10 12340000  11 00000050  12 12340000
13 00000058  15 00000011  15 00000111
16 00000149  17 00000005  31 00000050
18 000000aa  21 fffffffb  22 000000fa
23 a0000000  24 00000001
